/* rtl/cd_pkg.sv */
// Register map, interrupt bits, reset defaults and page geometry shared by the CDBUS node
package cd_pkg;

    typedef enum logic [3:0] {
        VERSION       = 4'd0,
        SETTING       = 4'd1,
        IDLE_WAIT_LEN = 4'd2,
        TX_PERMIT_LEN = 4'd3,
        MAX_IDLE_LEN  = 4'd4,
        TX_PRE_LEN    = 4'd5,
        FILTER        = 4'd6,
        DIV_LS        = 4'd7,
        DIV_HS        = 4'd8,
        INT_MASK      = 4'd9,
        INT_FLAG      = 4'd10,
        RX            = 4'd11,
        TX            = 4'd12,
        RX_CTRL       = 4'd13,
        TX_CTRL       = 4'd14,
        FILTER_M      = 4'd15
    } cd_reg_e;

    // INT_FLAG bit positions, bits 6 and 7 read zero
    localparam int INT_BUS_IDLE   = 0;
    localparam int INT_RX_PENDING = 1;
    localparam int INT_RX_BREAK   = 2;
    localparam int INT_RX_LOST    = 3;
    localparam int INT_RX_ERROR   = 4;
    localparam int INT_TX_FREE    = 5;

    localparam logic [7:0]  CD_VERSION        = 8'h0f;
    localparam logic [7:0]  DEF_IDLE_WAIT_LEN = 8'd10;
    localparam logic [9:0]  DEF_TX_PERMIT_LEN = 10'd20;
    localparam logic [9:0]  DEF_MAX_IDLE_LEN  = 10'd200;
    localparam logic [1:0]  DEF_TX_PRE_LEN    = 2'd1;
    localparam logic [7:0]  DEF_FILTER        = 8'hff;
    localparam logic [15:0] DEF_DIV           = 16'd346;  // 115200 bps at 40 MHz
    localparam logic [1:0]  DEF_MODE          = 2'd1;     // Arbitration

    localparam int PAGE_WORDS   = 64;
    localparam int PAGE_AW      = 6;
    localparam int LEN_W        = 9;    // Frame length incl. header, up to 256
    localparam int MAX_DATA_LEN = 253;
    localparam int HDR_BYTES    = 3;

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        COPY,
        COMMIT,
        DROP
    } mover_state_e;

endpackage

/* rtl/cd_tx_page_if.sv */
// Host write side and mover read side of the transmit page pair
`timescale 1ns/10ps

interface cd_tx_page_if;
    import cd_pkg::*;

    logic               wr_en;
    logic [PAGE_AW-1:0] wr_addr;
    logic [31:0]        wr_data;
    logic               switch_page;
    logic               abort;
    logic               pending;
    logic [PAGE_AW-1:0] rd_addr;
    logic [31:0]        rd_word;
    logic               take;
    logic               done;

    modport csr (output wr_en, wr_addr, wr_data, switch_page, abort, input pending);
    modport pages (input wr_en, wr_addr, wr_data, switch_page, abort, rd_addr, take, done,
                   output pending, rd_word);
    modport mover (output rd_addr, take, done, input rd_word, pending);

endinterface

/* rtl/cd_rx_page_if.sv */
// Mover write side and host read side of the receive page ring
`timescale 1ns/10ps

interface cd_rx_page_if;
    import cd_pkg::*;

    logic               wr_en;
    logic [PAGE_AW-1:0] wr_addr;
    logic [31:0]        wr_data;
    logic               commit;
    logic [LEN_W-1:0]   commit_len;
    logic               has_free;
    logic [PAGE_AW-1:0] rd_addr;
    logic [31:0]        rd_word;
    logic [LEN_W-1:0]   rd_len;
    logic               rd_done;
    logic               clean_all;
    logic               pending;
    logic               lost;

    modport csr (output rd_addr, rd_done, clean_all, input rd_word, rd_len, pending, lost);
    modport pages (input wr_en, wr_addr, wr_data, commit, commit_len, rd_addr, rd_done,
                   clean_all, output has_free, rd_word, rd_len, pending, lost);
    modport mover (output wr_en, wr_addr, wr_data, commit, commit_len, input has_free);

endinterface

/* rtl/cd_csr.sv */
// Host register block: settings, interrupt flags, page pointers and page control strobes
`timescale 1ns/10ps

module cd_csr (
    input  logic         clk,
    input  logic         reset_n,
    input  logic [3:0]   csr_address,
    input  logic         csr_read,
    input  logic         csr_write,
    input  logic [31:0]  csr_writedata,
    output logic [31:0]  csr_readdata,
    output logic         irq,
    input  logic         bus_idle,
    input  logic         rx_error,
    cd_tx_page_if.csr    tx_page,
    cd_rx_page_if.csr    rx_page,
    output logic         rx_invert,
    output logic         tx_invert,
    output logic         tx_push_pull,
    output logic         user_crc,
    output logic         full_duplex,
    output logic         break_sync,
    output logic         arbitration,
    output logic [7:0]   idle_wait_len,
    output logic [9:0]   tx_permit_len,
    output logic [9:0]   max_idle_len,
    output logic [1:0]   tx_pre_len,
    output logic [15:0]  div_ls,
    output logic [15:0]  div_hs,
    output logic [7:0]   filter,
    output logic [7:0]   filter_m0,
    output logic [7:0]   filter_m1
);
    import cd_pkg::*;

    cd_reg_e    reg_sel;
    logic       idle_invert;
    logic [1:0] mode_sel;
    logic [7:0] int_mask;
    logic [7:0] int_flag;
    logic       rx_lost_flag;
    logic       rx_error_flag;

    assign reg_sel = cd_reg_e'(csr_address);

    // ~~~~~~~~~~~~~~~~~~~~
    // Interrupts and mode decode

    always_comb begin
        int_flag                 = 8'd0;
        int_flag[INT_BUS_IDLE]   = bus_idle ^ idle_invert;
        int_flag[INT_RX_PENDING] = rx_page.pending;
        int_flag[INT_RX_BREAK]   = 1'b0;     // No break detection without a PHY
        int_flag[INT_RX_LOST]    = rx_lost_flag;
        int_flag[INT_RX_ERROR]   = rx_error_flag;
        int_flag[INT_TX_FREE]    = ~tx_page.pending;
    end

    assign irq         = |(int_flag & int_mask);
    assign arbitration = mode_sel == 2'd1;
    assign break_sync  = mode_sel == 2'd2;
    assign full_duplex = mode_sel == 2'd3;

    assign tx_page.wr_en   = csr_write && (reg_sel == TX);
    assign tx_page.wr_data = csr_writedata;

    // ~~~~~~~~~~~~~~~~~~~~
    // Read data

    always_comb begin
        case (reg_sel)
            VERSION:       csr_readdata = {24'd0, CD_VERSION};
            SETTING:       csr_readdata = {24'd0, idle_invert, rx_invert, mode_sel, 1'b0,
                                           user_crc, tx_invert, tx_push_pull};
            IDLE_WAIT_LEN: csr_readdata = {24'd0, idle_wait_len};
            TX_PERMIT_LEN: csr_readdata = {22'd0, tx_permit_len};
            MAX_IDLE_LEN:  csr_readdata = {22'd0, max_idle_len};
            TX_PRE_LEN:    csr_readdata = {30'd0, tx_pre_len};
            FILTER:        csr_readdata = {24'd0, filter};
            DIV_LS:        csr_readdata = {16'd0, div_ls};
            DIV_HS:        csr_readdata = {16'd0, div_hs};
            INT_MASK:      csr_readdata = {24'd0, int_mask};
            INT_FLAG:      csr_readdata = {{(24 - LEN_W){1'b0}}, rx_page.rd_len, int_flag};
            RX:            csr_readdata = rx_page.rd_word;
            FILTER_M:      csr_readdata = {16'd0, filter_m1, filter_m0};
            default:       csr_readdata = 32'd0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Registers, flags and strobes

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idle_invert         <= 1'b0;
            rx_invert           <= 1'b0;
            mode_sel            <= DEF_MODE;
            user_crc            <= 1'b0;
            tx_invert           <= 1'b0;
            tx_push_pull        <= 1'b0;
            idle_wait_len       <= DEF_IDLE_WAIT_LEN;
            tx_permit_len       <= DEF_TX_PERMIT_LEN;
            max_idle_len        <= DEF_MAX_IDLE_LEN;
            tx_pre_len          <= DEF_TX_PRE_LEN;
            filter              <= DEF_FILTER;
            filter_m0           <= DEF_FILTER;
            filter_m1           <= DEF_FILTER;
            div_ls              <= DEF_DIV;
            div_hs              <= DEF_DIV;
            int_mask            <= 8'd0;
            rx_lost_flag        <= 1'b0;
            rx_error_flag       <= 1'b0;
            tx_page.wr_addr     <= '0;
            tx_page.switch_page <= 1'b0;
            tx_page.abort       <= 1'b0;
            rx_page.rd_addr     <= '0;
            rx_page.rd_done     <= 1'b0;
            rx_page.clean_all   <= 1'b0;
        end else begin
            tx_page.switch_page <= 1'b0;
            tx_page.abort       <= 1'b0;
            rx_page.rd_done     <= 1'b0;
            rx_page.clean_all   <= 1'b0;

            if (csr_read && reg_sel == INT_FLAG) begin
                rx_lost_flag  <= 1'b0;
                rx_error_flag <= 1'b0;
            end
            if (csr_read && reg_sel == RX) begin
                rx_page.rd_addr <= rx_page.rd_addr + 1'b1;
            end

            // New events win over a clearing read
            if (rx_page.lost) begin
                rx_lost_flag <= 1'b1;
            end
            if (rx_error) begin
                rx_error_flag <= 1'b1;
            end

            if (csr_write) begin
                case (reg_sel)
                    SETTING: begin
                        idle_invert  <= csr_writedata[7];
                        rx_invert    <= csr_writedata[6];
                        mode_sel     <= csr_writedata[5:4];
                        user_crc     <= csr_writedata[2];
                        tx_invert    <= csr_writedata[1];
                        tx_push_pull <= csr_writedata[0];
                    end
                    IDLE_WAIT_LEN: idle_wait_len <= csr_writedata[7:0];
                    TX_PERMIT_LEN: tx_permit_len <= csr_writedata[9:0];
                    MAX_IDLE_LEN:  max_idle_len <= csr_writedata[9:0];
                    TX_PRE_LEN:    tx_pre_len <= csr_writedata[1:0];
                    FILTER:        filter <= csr_writedata[7:0];
                    DIV_LS:        div_ls <= csr_writedata[15:0];
                    DIV_HS:        div_hs <= csr_writedata[15:0];
                    INT_MASK:      int_mask <= csr_writedata[7:0];
                    TX:            tx_page.wr_addr <= tx_page.wr_addr + 1'b1;
                    RX_CTRL: begin
                        rx_page.clean_all <= csr_writedata[4];
                        rx_page.rd_done   <= csr_writedata[1];
                        rx_page.rd_addr   <= '0;
                    end
                    TX_CTRL: begin
                        tx_page.abort       <= csr_writedata[4];
                        tx_page.switch_page <= csr_writedata[1];
                        tx_page.wr_addr     <= '0;
                    end
                    FILTER_M: begin
                        filter_m0 <= csr_writedata[7:0];
                        filter_m1 <= csr_writedata[15:8];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* rtl/cd_tx_pages.sv */
// Double-buffered transmit page memory, filled by the host and emptied by the mover
`timescale 1ns/10ps

module cd_tx_pages (
    input  logic         clk,
    input  logic         reset_n,
    cd_tx_page_if.pages  tx
);
    import cd_pkg::*;

    logic [31:0] mem [0:2*PAGE_WORDS-1];
    logic        wr_sel;    // Page the host is filling
    logic        rd_sel;
    logic [1:0]  pend;
    logic        busy;      // Pending page taken by the mover

    // Only the page opposite the write page can ever be pending
    assign rd_sel     = ~wr_sel;
    assign tx.pending = |pend;
    assign tx.rd_word = mem[{rd_sel, tx.rd_addr}];

    always_ff @(posedge clk) begin
        if (tx.wr_en) begin
            mem[{wr_sel, tx.wr_addr}] <= tx.wr_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_sel <= 1'b0;
            pend   <= 2'b00;
            busy   <= 1'b0;
        end else begin
            if (tx.take) begin
                busy <= 1'b1;
            end
            if (tx.done) begin
                busy         <= 1'b0;
                pend[rd_sel] <= 1'b0;
            end
            if (tx.abort && !busy) begin
                pend[rd_sel] <= 1'b0;
            end
            // Switch is dropped while the other page still waits
            if (tx.switch_page && !pend[rd_sel]) begin
                pend[wr_sel] <= 1'b1;
                wr_sel       <= ~wr_sel;
            end
        end
    end

endmodule

/* rtl/cd_rx_pages.sv */
// Two-page receive ring with frame lengths, head page read-out and frame loss detection
`timescale 1ns/10ps

module cd_rx_pages (
    input  logic         clk,
    input  logic         reset_n,
    cd_rx_page_if.pages  rx
);
    import cd_pkg::*;

    logic [31:0]      mem [0:2*PAGE_WORDS-1];
    logic [LEN_W-1:0] len [0:1];
    logic [1:0]       full;
    logic             wr_ptr;   // Next page to fill
    logic             rd_ptr;   // Head page seen by the host
    logic             filled;   // Current frame has landed in the write page
    logic             wr_ok;

    assign wr_ok       = rx.wr_en && rx.has_free;
    assign rx.has_free = ~full[wr_ptr];
    assign rx.pending  = full[rd_ptr];
    assign rx.rd_word  = mem[{rd_ptr, rx.rd_addr}];
    assign rx.rd_len   = len[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[{wr_ptr, rx.wr_addr}] <= rx.wr_data;
        end
        if (rx.commit && filled) begin
            len[wr_ptr] <= rx.commit_len;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full    <= 2'b00;
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            filled  <= 1'b0;
            rx.lost <= 1'b0;
        end else begin
            // A commit with nothing written means the frame found no room
            rx.lost <= rx.commit && !filled;

            if (wr_ok) begin
                filled <= 1'b1;
            end

            if (rx.clean_all) begin
                full   <= 2'b00;
                rd_ptr <= wr_ptr;
            end else if (rx.rd_done && full[rd_ptr]) begin
                full[rd_ptr] <= 1'b0;
                rd_ptr       <= ~rd_ptr;
            end

            if (rx.commit) begin
                filled <= 1'b0;
                if (filled) begin
                    full[wr_ptr] <= 1'b1;
                    wr_ptr       <= ~wr_ptr;
                end
            end
        end
    end

endmodule

/* rtl/cd_loopback.sv */
// Local loopback engine moving committed transmit frames into free receive pages
`timescale 1ns/10ps

module cd_loopback (
    input  logic         clk,
    input  logic         reset_n,
    input  logic [7:0]   filter,
    input  logic [7:0]   filter_m0,
    input  logic [7:0]   filter_m1,
    cd_tx_page_if.mover  tx,
    cd_rx_page_if.mover  rx,
    output logic         bus_idle,
    output logic         rx_error
);
    import cd_pkg::*;

    mover_state_e       state;
    logic [PAGE_AW-1:0] addr;
    logic [PAGE_AW-1:0] last_addr;
    logic [7:0]         len_q;
    logic [7:0]         hdr_dst;
    logic [7:0]         hdr_len;
    logic [LEN_W-1:0]   hdr_words;
    logic               accept;
    logic               too_long;

    // Header word is src, dst, len from the low byte up
    assign hdr_dst   = tx.rd_word[15:8];
    assign hdr_len   = tx.rd_word[23:16];
    assign hdr_words = (LEN_W'(hdr_len) + LEN_W'(HDR_BYTES) + LEN_W'(3)) >> 2;
    assign too_long  = hdr_len > MAX_DATA_LEN;
    assign accept    = (hdr_dst == filter) || (hdr_dst == filter_m0) ||
                       (hdr_dst == filter_m1) || (hdr_dst == 8'hff);

    assign bus_idle      = state == IDLE;
    assign rx_error      = (state == HEADER) && too_long;
    assign tx.take       = (state == IDLE) && tx.pending;
    assign tx.done       = (state == COMMIT) || (state == DROP);
    assign tx.rd_addr    = (state == COPY) ? addr : '0;
    assign rx.wr_en      = state == COPY;
    assign rx.wr_addr    = addr;
    assign rx.wr_data    = tx.rd_word;
    assign rx.commit     = state == COMMIT;
    assign rx.commit_len = LEN_W'(len_q) + LEN_W'(HDR_BYTES);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
            addr  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (tx.pending) begin
                        state <= HEADER;
                    end
                end
                HEADER: begin
                    addr <= '0;
                    if (too_long || !accept) begin
                        state <= DROP;
                    end else if (!rx.has_free) begin
                        state <= COMMIT;    // Empty commit, flagged as lost
                    end else begin
                        state <= COPY;
                    end
                end
                COPY: begin
                    addr <= addr + 1'b1;
                    if (addr == last_addr) begin
                        state <= COMMIT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == HEADER) begin
            len_q     <= hdr_len;
            last_addr <= PAGE_AW'(hdr_words - 1'b1);
        end
    end

endmodule

/* rtl/cd_top.sv */
// CDBUS node top level: register block, page memories and loopback engine
`timescale 1ns/10ps

module cd_top (
    input  logic         clk,
    input  logic         reset_n,
    input  logic [3:0]   csr_address,
    input  logic         csr_read,
    input  logic         csr_write,
    input  logic [31:0]  csr_writedata,
    output logic [31:0]  csr_readdata,
    output logic         irq,
    output logic         rx_invert,
    output logic         tx_invert,
    output logic         tx_push_pull,
    output logic         user_crc,
    output logic         full_duplex,
    output logic         break_sync,
    output logic         arbitration,
    output logic [7:0]   idle_wait_len,
    output logic [9:0]   tx_permit_len,
    output logic [9:0]   max_idle_len,
    output logic [1:0]   tx_pre_len,
    output logic [15:0]  div_ls,
    output logic [15:0]  div_hs,
    output logic [7:0]   filter,
    output logic [7:0]   filter_m0,
    output logic [7:0]   filter_m1
);

    logic bus_idle;
    logic rx_error;

    cd_tx_page_if tx_page ();
    cd_rx_page_if rx_page ();

    // Names match one to one, interfaces included
    cd_csr cd_csr_inst (.*);

    cd_tx_pages cd_tx_pages_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .tx      (tx_page)
    );

    cd_rx_pages cd_rx_pages_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .rx      (rx_page)
    );

    cd_loopback cd_loopback_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .filter    (filter),
        .filter_m0 (filter_m0),
        .filter_m1 (filter_m1),
        .tx        (tx_page),
        .rx        (rx_page),
        .bus_idle  (bus_idle),
        .rx_error  (rx_error)
    );

endmodule

/* bench/cd_top_tb.sv */
// Testbench for the CDBUS node: register defaults, readback, loopback, filter, loss and error
`timescale 1ns/10ps

module cd_top_tb;
    import cd_pkg::*;

    localparam int WAIT_LIMIT   = 400;     // Cycles allowed for one frame to move
    localparam int FRAME_CYCLES = 1000;    // Host writes, move and read-out of one full frame
    localparam int NUM_FRAMES   = 10;
    localparam int WATCHDOG_NS  = NUM_FRAMES * FRAME_CYCLES * 20;

    logic        clk;
    logic        reset_n;
    logic [3:0]  csr_address;
    logic        csr_read;
    logic        csr_write;
    logic [31:0] csr_writedata;
    logic [31:0] csr_readdata;
    logic        irq;
    logic        rx_invert;
    logic        tx_invert;
    logic        tx_push_pull;
    logic        user_crc;
    logic        full_duplex;
    logic        break_sync;
    logic        arbitration;
    logic [7:0]  idle_wait_len;
    logic [9:0]  tx_permit_len;
    logic [9:0]  max_idle_len;
    logic [1:0]  tx_pre_len;
    logic [15:0] div_ls;
    logic [15:0] div_hs;
    logic [7:0]  filter;
    logic [7:0]  filter_m0;
    logic [7:0]  filter_m1;

    int          errors;
    int          checks;
    integer      seed;
    int          frame_words;
    logic [31:0] frame [0:PAGE_WORDS-1];    // Last frame sent, as written to TX

    cd_reg_e     rw_regs [0:8] = '{IDLE_WAIT_LEN, TX_PERMIT_LEN, MAX_IDLE_LEN, TX_PRE_LEN,
                                   FILTER, DIV_LS, DIV_HS, INT_MASK, FILTER_M};
    logic [31:0] rw_masks [0:8] = '{32'hff, 32'h3ff, 32'h3ff, 32'h3, 32'hff,
                                    32'hffff, 32'hffff, 32'hff, 32'hffff};

    cd_top cd_top_inst (.*);

    always #10 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus and check tasks

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic csr_wr(input cd_reg_e addr, input logic [31:0] data);
        csr_address   = addr;
        csr_writedata = data;
        csr_write     = 1'b1;
        @(posedge clk);
        #1;
        csr_write = 1'b0;
    endtask

    task automatic csr_rd(input cd_reg_e addr, output logic [31:0] data);
        csr_address = addr;
        csr_read    = 1'b1;
        @(negedge clk);               // Read data settles well before the edge
        data = csr_readdata;
        @(posedge clk);
        #1;
        csr_read = 1'b0;
    endtask

    task automatic read_check(input string name, input cd_reg_e addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        csr_rd(addr, data);
        check(name, expected, data);
    endtask

    task automatic check_flags(input string name, input logic [7:0] expected);
        logic [31:0] data;
        csr_rd(INT_FLAG, data);
        check(name, {24'd0, expected}, {24'd0, data[7:0]});
    endtask

    // Top-level configuration output behind a settings register
    function automatic logic [31:0] config_output(input cd_reg_e addr);
        case (addr)
            IDLE_WAIT_LEN: config_output = {24'd0, idle_wait_len};
            TX_PERMIT_LEN: config_output = {22'd0, tx_permit_len};
            MAX_IDLE_LEN:  config_output = {22'd0, max_idle_len};
            TX_PRE_LEN:    config_output = {30'd0, tx_pre_len};
            FILTER:        config_output = {24'd0, filter};
            DIV_LS:        config_output = {16'd0, div_ls};
            DIV_HS:        config_output = {16'd0, div_hs};
            FILTER_M:      config_output = {16'd0, filter_m1, filter_m0};
            default:       config_output = 32'd0;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Frame tasks

    task automatic send_frame(input logic [7:0] src, input logic [7:0] dst, input int len);
        int i;
        frame_words = (HDR_BYTES + len + 3) / 4;
        if (frame_words > PAGE_WORDS) begin
            frame_words = PAGE_WORDS;    // An over-long frame fills the whole page
        end
        for (i = 0; i < frame_words; i++) begin
            frame[i] = $random(seed);
        end
        frame[0][7:0]   = src;
        frame[0][15:8]  = dst;
        frame[0][23:16] = 8'(len);
        for (i = 0; i < frame_words; i++) begin
            csr_wr(TX, frame[i]);
        end
        csr_wr(TX_CTRL, 32'h2);       // Switch page
    endtask

    task automatic wait_rx_pending(input string name);
        int n;
        logic [31:0] flags;
        n     = 0;
        flags = '0;
        while (!flags[INT_RX_PENDING] && n < WAIT_LIMIT) begin
            csr_rd(INT_FLAG, flags);
            n++;
        end
        if (!flags[INT_RX_PENDING]) begin
            $display("%s: no receive page became pending in time", name);
            errors++;
        end
    endtask

    // Waits on irq so that the sticky flags survive
    task automatic wait_tx_free(input string name);
        int n;
        csr_wr(INT_MASK, 32'(1 << INT_TX_FREE));
        idle(2);
        n = 0;
        while (!irq && n < WAIT_LIMIT) begin
            idle(1);
            n++;
        end
        if (!irq) begin
            $display("%s: transmit page was never released", name);
            errors++;
        end
        csr_wr(INT_MASK, 32'h0);
    endtask

    task automatic check_frame(input string name, input int len);
        int i;
        logic [31:0] data;
        csr_rd(INT_FLAG, data);
        check({name, " rd_len"}, 32'(HDR_BYTES + len), {23'd0, data[16:8]});
        csr_wr(RX_CTRL, 32'h0);       // Read pointer back to word 0
        for (i = 0; i < frame_words; i++) begin
            csr_rd(RX, data);
            check($sformatf("%s word %0d", name, i), frame[i], data);
        end
    endtask

    task automatic receive_frame(input string name, input logic [7:0] dst, input int len);
        send_frame(8'h01, dst, len);
        wait_rx_pending(name);
        check_frame(name, len);
        csr_wr(RX_CTRL, 32'h2);
        idle(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Tests

    initial begin
        int i;
        int len;
        logic [31:0] value;
        logic [7:0] base_flags;
        errors        = 0;
        checks        = 0;
        seed          = 81;
        clk           = 1'b0;
        reset_n       = 1'b0;
        csr_address   = 4'd0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = 32'd0;
        base_flags    = 8'((1 << INT_BUS_IDLE) | (1 << INT_TX_FREE));
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        idle(1);

        // Reset defaults
        read_check("VERSION", VERSION, 32'h0f);
        read_check("SETTING", SETTING, 32'h10);
        read_check("IDLE_WAIT_LEN", IDLE_WAIT_LEN, 32'd10);
        read_check("TX_PERMIT_LEN", TX_PERMIT_LEN, 32'd20);
        read_check("MAX_IDLE_LEN", MAX_IDLE_LEN, 32'd200);
        read_check("TX_PRE_LEN", TX_PRE_LEN, 32'd1);
        read_check("FILTER", FILTER, 32'hff);
        read_check("DIV_LS", DIV_LS, 32'd346);
        read_check("DIV_HS", DIV_HS, 32'd346);
        read_check("INT_MASK", INT_MASK, 32'd0);
        read_check("FILTER_M", FILTER_M, 32'hffff);
        check_flags("reset INT_FLAG", base_flags);
        check("reset irq", 32'd0, {31'd0, irq});
        check("reset arbitration", 32'd1, {31'd0, arbitration});

        // Settings readback
        for (i = 0; i < 9; i++) begin
            value = $random(seed);
            csr_wr(rw_regs[i], value);
            read_check(rw_regs[i].name(), rw_regs[i], value & rw_masks[i]);
            if (rw_regs[i] != INT_MASK) begin
                check($sformatf("%s output", rw_regs[i].name()), value & rw_masks[i],
                      config_output(rw_regs[i]));
            end
        end
        csr_wr(INT_MASK, 32'h0);
        csr_wr(SETTING, 32'hff);
        read_check("SETTING all ones", SETTING, 32'hf7);    // Bit 3 is not stored
        check("setting outputs", 32'hf, {28'd0, rx_invert, tx_invert, tx_push_pull, user_crc});
        check_flags("idle inverted INT_FLAG", base_flags ^ 8'(1 << INT_BUS_IDLE));
        for (i = 0; i < 4; i++) begin
            csr_wr(SETTING, 32'(i << 4));
            check($sformatf("mode %0d decode", i), {29'd0, i == 1, i == 2, i == 3},
                  {29'd0, arbitration, break_sync, full_duplex});
        end
        csr_wr(SETTING, 32'h10);

        // Loopback of an accepted frame
        csr_wr(FILTER, 32'h12);
        csr_wr(FILTER_M, 32'h3456);
        check("filter_m outputs", 32'h3456, {16'd0, filter_m1, filter_m0});
        len = $unsigned($random(seed)) % (MAX_DATA_LEN + 1);
        send_frame(8'h01, 8'h12, len);
        wait_rx_pending("loopback");
        check_frame("loopback", len);
        csr_wr(INT_MASK, 32'(1 << INT_RX_PENDING));
        check("loopback irq set", 32'd1, {31'd0, irq});
        csr_wr(RX_CTRL, 32'h2);
        check("loopback irq held", 32'd1, {31'd0, irq});
        idle(1);
        check("loopback irq clear", 32'd0, {31'd0, irq});
        csr_wr(INT_MASK, 32'h0);

        // Filter
        send_frame(8'h02, 8'h77, 20);
        wait_tx_free("unmatched");
        check_flags("unmatched INT_FLAG", base_flags);
        receive_frame("filter_m1", 8'h34, $unsigned($random(seed)) % 64);
        receive_frame("broadcast", 8'hff, $unsigned($random(seed)) % 64);

        // Loss and error flags
        for (i = 0; i < 3; i++) begin
            send_frame(8'h03, 8'h12, 8 + i);
            wait_tx_free("loss");
        end
        send_frame(8'h03, 8'h12, 254);
        wait_tx_free("error");
        check_flags("lost and error set", base_flags | 8'((1 << INT_RX_PENDING) |
                    (1 << INT_RX_LOST) | (1 << INT_RX_ERROR)));
        check_flags("lost and error cleared", base_flags | 8'(1 << INT_RX_PENDING));
        csr_wr(RX_CTRL, 32'h10);
        idle(1);
        check_flags("clean all", base_flags);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
rtl/cd_pkg.sv
rtl/cd_tx_page_if.sv
rtl/cd_rx_page_if.sv
rtl/cd_csr.sv
rtl/cd_tx_pages.sv
rtl/cd_rx_pages.sv
rtl/cd_loopback.sv
rtl/cd_top.sv
bench/cd_top_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = cd_top_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
